// ==== logic/ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

    // architectural register count, x0 included
    localparam int REG_COUNT = 32;

    // register value
    typedef logic [31:0] data_t;

    // program counter
    typedef logic [31:0] addr_t;

    // architectural register number
    typedef logic [4:0] reg_idx_t;

    // reorder buffer tag, room for up to 16 entries
    typedef logic [3:0] tag_t;

    // set at allocation, picks the retirement path
    typedef enum logic [1:0] {
        kind_alu,
        kind_branch,
        kind_store
    } entry_kind_e;

    // head FSM of the reorder buffer
    typedef enum logic [1:0] {
        st_run,
        st_store_wait,
        st_flush
    } rob_state_e;

endpackage

`default_nettype wire

// ==== logic/commit_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one retirement per cycle, reorder buffer to regfile and rename table
interface commit_if;

    logic              en;
    ooo_pkg::reg_idx_t rd;
    ooo_pkg::data_t    data;
    ooo_pkg::tag_t     tag;

    modport src (
        output en,
        output rd,
        output data,
        output tag
    );

    modport dst (
        input en,
        input rd,
        input data,
        input tag
    );

endinterface

`default_nettype wire

// ==== logic/reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 alloc_en,
    input  ooo_pkg::reg_idx_t    alloc_rd,
    input  ooo_pkg::entry_kind_e alloc_kind,
    input  logic                 alloc_pred_taken,
    output logic                 alloc_ready,
    output ooo_pkg::tag_t        alloc_tag,
    input  logic                 wb_en,
    input  ooo_pkg::tag_t        wb_tag,
    input  ooo_pkg::data_t       wb_data,
    input  logic                 wb_taken,
    input  ooo_pkg::addr_t       wb_target,
    input  logic                 store_done,
    output logic                 store_en,
    output ooo_pkg::tag_t        store_tag,
    output logic                 flush,
    output ooo_pkg::addr_t       redirect_pc,
    commit_if.src                cmt
);

    localparam int PTR_W = $clog2(ROB_DEPTH);
    localparam int CNT_W = $clog2(ROB_DEPTH + 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(ROB_DEPTH);

    typedef logic [PTR_W-1:0] ptr_t;

    // per-entry control
    logic [ROB_DEPTH-1:0] valid;
    logic [ROB_DEPTH-1:0] done;

    // per-entry payload
    ooo_pkg::entry_kind_e kind       [ROB_DEPTH];
    ooo_pkg::reg_idx_t    rd_arr     [ROB_DEPTH];
    ooo_pkg::data_t       data_arr   [ROB_DEPTH];
    logic                 pred_taken [ROB_DEPTH];
    logic                 act_taken  [ROB_DEPTH];
    ooo_pkg::addr_t       target     [ROB_DEPTH];

    ptr_t                rd_ptr;
    ptr_t                wr_ptr;
    logic [CNT_W-1:0]    count;
    ooo_pkg::rob_state_e state;
    ooo_pkg::rob_state_e state_next;

    logic full;
    logic empty;
    logic alloc_fire;
    ptr_t wb_idx;
    logic wb_hit;
    logic head_live;
    logic head_store;
    logic head_mispredict;
    logic head_writes;
    logic flush_start;
    logic retire;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);

    assign alloc_ready = !full && (state != ooo_pkg::st_flush);
    assign alloc_tag   = ooo_pkg::tag_t'(wr_ptr);
    assign alloc_fire  = alloc_en && alloc_ready;

    // late or duplicate writebacks are dropped
    assign wb_idx = wb_tag[PTR_W-1:0];
    assign wb_hit = wb_en && valid[wb_idx] && !done[wb_idx];

    always_comb begin
        head_live       = (state == ooo_pkg::st_run) && !empty && done[rd_ptr];
        head_store      = (kind[rd_ptr] == ooo_pkg::kind_store);
        head_mispredict = (kind[rd_ptr] == ooo_pkg::kind_branch)
                          && (pred_taken[rd_ptr] != act_taken[rd_ptr]);
        // branches only write for jal-style links
        head_writes     = (kind[rd_ptr] == ooo_pkg::kind_alu)
                          || ((kind[rd_ptr] == ooo_pkg::kind_branch) && (rd_arr[rd_ptr] != '0));
        flush_start     = head_live && head_mispredict;
        retire          = (head_live && !head_store)
                          || ((state == ooo_pkg::st_store_wait) && store_done);
    end

    always_comb begin
        state_next = state;
        case (state)
            ooo_pkg::st_run: begin
                if (head_live && head_store) begin
                    state_next = ooo_pkg::st_store_wait;
                end else if (flush_start) begin
                    state_next = ooo_pkg::st_flush;
                end
            end
            ooo_pkg::st_store_wait: begin
                if (store_done) begin
                    state_next = ooo_pkg::st_run;
                end
            end
            default: state_next = ooo_pkg::st_run;
        endcase
    end

    assign cmt.en   = head_live && !head_store && head_writes;
    assign cmt.rd   = rd_arr[rd_ptr];
    assign cmt.data = data_arr[rd_ptr];
    assign cmt.tag  = ooo_pkg::tag_t'(rd_ptr);

    assign store_en  = (state == ooo_pkg::st_store_wait);
    assign store_tag = ooo_pkg::tag_t'(rd_ptr);
    assign flush     = (state == ooo_pkg::st_flush);

    // the flush cycle empties the whole buffer at its closing edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid  <= '0;
            done   <= '0;
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
            state  <= ooo_pkg::st_run;
        end else begin
            state <= state_next;
            if (alloc_fire) begin
                valid[wr_ptr] <= 1'b1;
                done[wr_ptr]  <= 1'b0;
                wr_ptr        <= wr_ptr + 1'b1;
            end
            if (wb_hit) begin
                done[wb_idx] <= 1'b1;
            end
            if (retire) begin
                valid[rd_ptr] <= 1'b0;
                rd_ptr        <= rd_ptr + 1'b1;
            end
            case ({alloc_fire, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            kind[wr_ptr]       <= alloc_kind;
            rd_arr[wr_ptr]     <= alloc_rd;
            pred_taken[wr_ptr] <= alloc_pred_taken;
        end
        if (wb_hit) begin
            data_arr[wb_idx]  <= wb_data;
            act_taken[wb_idx] <= wb_taken;
            target[wb_idx]    <= wb_target;
        end
        // target held through the flush cycle
        if (flush_start) begin
            redirect_pc <= target[rd_ptr];
        end
    end

endmodule

`default_nettype wire

// ==== logic/rename_table.sv ====
`timescale 1ns/1ps
`default_nettype none

module rename_table (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_fire,
    input  ooo_pkg::reg_idx_t alloc_rd,
    input  ooo_pkg::tag_t     alloc_tag,
    input  logic              flush,
    commit_if.dst             cmt,
    input  ooo_pkg::reg_idx_t lookup_rs,
    output logic              lookup_pending,
    output ooo_pkg::tag_t     lookup_tag
);

    logic [ooo_pkg::REG_COUNT-1:0] pending;
    ooo_pkg::tag_t                 owner [ooo_pkg::REG_COUNT];

    logic alloc_claim;
    logic commit_clear;

    // x0 is never renamed
    assign alloc_claim = alloc_fire && (alloc_rd != '0);

    // a newer producer keeps the register pending
    assign commit_clear = cmt.en && pending[cmt.rd] && (owner[cmt.rd] == cmt.tag);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending <= '0;
        end else begin
            if (commit_clear) begin
                pending[cmt.rd] <= 1'b0;
            end
            // allocation overrides a commit to the same register
            if (alloc_claim) begin
                pending[alloc_rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_claim) begin
            owner[alloc_rd] <= alloc_tag;
        end
    end

    assign lookup_pending = pending[lookup_rs];
    assign lookup_tag     = owner[lookup_rs];

endmodule

`default_nettype wire

// ==== logic/arch_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module arch_regfile (
    input  logic              clk,
    input  logic              rst,
    commit_if.dst             cmt,
    input  ooo_pkg::reg_idx_t lookup_rs,
    input  logic              lookup_pending,
    input  ooo_pkg::tag_t     lookup_tag,
    output logic              lookup_ready,
    output ooo_pkg::data_t    lookup_value,
    output ooo_pkg::tag_t     lookup_tag_out
);

    ooo_pkg::data_t regs [ooo_pkg::REG_COUNT];

    // x0 stays at its reset value
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ooo_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (cmt.en && (cmt.rd != '0)) begin
            regs[cmt.rd] <= cmt.data;
        end
    end

    // no same-cycle bypass from commit
    assign lookup_ready   = !lookup_pending;
    assign lookup_value   = lookup_pending ? '0 : regs[lookup_rs];
    assign lookup_tag_out = lookup_pending ? lookup_tag : '0;

endmodule

`default_nettype wire

// ==== logic/ooo_backend.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_backend #(
    parameter int ROB_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst,

    // allocation
    input  logic                 alloc_en,
    input  ooo_pkg::reg_idx_t    alloc_rd,
    input  ooo_pkg::entry_kind_e alloc_kind,
    input  logic                 alloc_pred_taken,
    output logic                 alloc_ready,
    output ooo_pkg::tag_t        alloc_tag,

    // completion
    input  logic                 wb_en,
    input  ooo_pkg::tag_t        wb_tag,
    input  ooo_pkg::data_t       wb_data,
    input  logic                 wb_taken,
    input  ooo_pkg::addr_t       wb_target,

    // store unit
    output logic                 store_en,
    output ooo_pkg::tag_t        store_tag,
    input  logic                 store_done,

    // operand lookup
    input  ooo_pkg::reg_idx_t    lookup_rs,
    output logic                 lookup_ready,
    output ooo_pkg::data_t       lookup_value,
    output ooo_pkg::tag_t        lookup_tag,

    // retirement and redirect
    output logic                 commit_en,
    output ooo_pkg::reg_idx_t    commit_rd,
    output ooo_pkg::data_t       commit_data,
    output logic                 flush,
    output ooo_pkg::addr_t       redirect_pc
);

    logic          alloc_fire;
    logic          rn_pending;
    ooo_pkg::tag_t rn_tag;

    commit_if cmt_bus ();

    assign alloc_fire = alloc_en && alloc_ready;

    reorder_buffer #(
        .ROB_DEPTH (ROB_DEPTH)
    ) u_rob (
        .clk              (clk),
        .rst              (rst),
        .alloc_en         (alloc_en),
        .alloc_rd         (alloc_rd),
        .alloc_kind       (alloc_kind),
        .alloc_pred_taken (alloc_pred_taken),
        .alloc_ready      (alloc_ready),
        .alloc_tag        (alloc_tag),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_data          (wb_data),
        .wb_taken         (wb_taken),
        .wb_target        (wb_target),
        .store_done       (store_done),
        .store_en         (store_en),
        .store_tag        (store_tag),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .cmt              (cmt_bus.src)
    );

    rename_table u_rename (
        .clk            (clk),
        .rst            (rst),
        .alloc_fire     (alloc_fire),
        .alloc_rd       (alloc_rd),
        .alloc_tag      (alloc_tag),
        .flush          (flush),
        .cmt            (cmt_bus.dst),
        .lookup_rs      (lookup_rs),
        .lookup_pending (rn_pending),
        .lookup_tag     (rn_tag)
    );

    arch_regfile u_regfile (
        .clk            (clk),
        .rst            (rst),
        .cmt            (cmt_bus.dst),
        .lookup_rs      (lookup_rs),
        .lookup_pending (rn_pending),
        .lookup_tag     (rn_tag),
        .lookup_ready   (lookup_ready),
        .lookup_value   (lookup_value),
        .lookup_tag_out (lookup_tag)
    );

    // retirement seen from outside
    assign commit_en   = cmt_bus.en;
    assign commit_rd   = cmt_bus.rd;
    assign commit_data = cmt_bus.data;

endmodule

`default_nettype wire

// ==== verif/ooo_backend_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_backend_tb;

    localparam int ROB_DEPTH = 8;

    logic                 clk;
    logic                 rst;
    logic                 alloc_en;
    ooo_pkg::reg_idx_t    alloc_rd;
    ooo_pkg::entry_kind_e alloc_kind;
    logic                 alloc_pred_taken;
    logic                 alloc_ready;
    ooo_pkg::tag_t        alloc_tag;
    logic                 wb_en;
    ooo_pkg::tag_t        wb_tag;
    ooo_pkg::data_t       wb_data;
    logic                 wb_taken;
    ooo_pkg::addr_t       wb_target;
    logic                 store_en;
    ooo_pkg::tag_t        store_tag;
    logic                 store_done;
    ooo_pkg::reg_idx_t    lookup_rs;
    logic                 lookup_ready;
    ooo_pkg::data_t       lookup_value;
    ooo_pkg::tag_t        lookup_tag;
    logic                 commit_en;
    ooo_pkg::reg_idx_t    commit_rd;
    ooo_pkg::data_t       commit_data;
    logic                 flush;
    ooo_pkg::addr_t       redirect_pc;

    int          errors;
    int          cmd_count;
    logic [7:0]  cmd_q [$];
    logic [31:0] arg_q [$];
    logic [31:0] held_tag;
    logic        commit_expected;
    logic        flush_expected;

    ooo_backend #(.ROB_DEPTH(ROB_DEPTH)) UUT (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("ERROR at %0t: %s expected %0h, got %0h", $time, name, expected, actual);
        end
    endtask

    // called near the falling edge, returns 2 ns after the next rising edge
    task automatic finish_cycle();
        logic fired;
        // a waiting request must keep its tag
        if (alloc_en) begin
            check_value("alloc_tag", held_tag, 32'(alloc_tag));
        end
        assert (!commit_en || commit_expected) else begin
            errors++;
            $display("unexpected commit of x%0d at %0t", commit_rd, $time);
        end
        assert (!flush || flush_expected) else begin
            errors++;
            $display("unexpected flush cycle at %0t", $time);
        end
        fired = alloc_en && alloc_ready;
        commit_expected = 1'b0;
        flush_expected = 1'b0;
        @(posedge clk);
        #2;
        wb_en = 1'b0;
        store_done = 1'b0;
        if (fired) begin
            alloc_en = 1'b0;
        end
    endtask

    task automatic read_stim();
        int fd;
        int n;
        int ch;
        logic [7:0] c;
        logic [31:0] a [4];
        fd = $fopen("verif/ooo_stim.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("could not open the stimulus file verif/ooo_stim.txt");
        end
        if (fd == 0) begin
            return;
        end
        n = $fscanf(fd, " %c", c);
        while (n == 1) begin
            for (int k = 0; k < 4; k++) begin
                a[k] = '0;
            end
            case (c)
                "#": begin
                    ch = 0;
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end
                "A", "W": n = $fscanf(fd, "%h %h %h %h", a[0], a[1], a[2], a[3]);
                "L":      n = $fscanf(fd, "%h %h %h", a[0], a[1], a[2]);
                "C":      n = $fscanf(fd, "%h %h", a[0], a[1]);
                default:  n = $fscanf(fd, "%h", a[0]);
            endcase
            if (c != "#") begin
                cmd_q.push_back(c);
                for (int k = 0; k < 4; k++) begin
                    arg_q.push_back(a[k]);
                end
            end
            n = $fscanf(fd, " %c", c);
        end
        $fclose(fd);
        cmd_count = cmd_q.size();
    endtask

    task automatic run_command(input logic [7:0] c, input logic [31:0] a0,
                               input logic [31:0] a1, input logic [31:0] a2,
                               input logic [31:0] a3);
        int waited;
        waited = 0;
        case (c)
            "A": begin
                assert (!alloc_en) else begin
                    errors++;
                    $display("allocation with tag %0h was never accepted", held_tag);
                end
                alloc_en = 1'b1;
                alloc_rd = a0[4:0];
                alloc_kind = ooo_pkg::entry_kind_e'(a1[1:0]);
                alloc_pred_taken = a2[0];
                held_tag = a3;
                #8;
                finish_cycle();
            end
            "W": begin
                wb_en = 1'b1;
                wb_tag = a0[3:0];
                wb_data = a1;
                wb_taken = a2[0];
                wb_target = a3;
                #8;
                finish_cycle();
            end
            "D": begin
                store_done = 1'b1;
                #8;
                check_value("store_en", 32'd1, 32'(store_en));
                check_value("store_tag", a0, 32'(store_tag));
                finish_cycle();
            end
            "L": begin
                lookup_rs = a0[4:0];
                #8;
                check_value("lookup_ready", a1, 32'(lookup_ready));
                if (a1[0]) begin
                    check_value("lookup_value", a2, lookup_value);
                end else begin
                    check_value("lookup_tag", a2, 32'(lookup_tag));
                end
                finish_cycle();
            end
            "C": begin
                #8;
                while (!commit_en && waited < 50) begin
                    finish_cycle();
                    #8;
                    waited++;
                end
                assert (commit_en) else begin
                    errors++;
                    $display("no commit of x%0d within 50 cycles at %0t", a0, $time);
                end
                if (commit_en) begin
                    check_value("commit_rd", a0, 32'(commit_rd));
                    check_value("commit_data", a1, commit_data);
                    commit_expected = 1'b1;
                end
                finish_cycle();
            end
            "F": begin
                #8;
                while (!flush && waited < 50) begin
                    finish_cycle();
                    #8;
                    waited++;
                end
                assert (flush) else begin
                    errors++;
                    $display("no flush within 50 cycles at %0t", $time);
                end
                if (flush) begin
                    check_value("redirect_pc", a0, redirect_pc);
                    check_value("alloc_ready", 32'd0, 32'(alloc_ready));
                    flush_expected = 1'b1;
                end
                finish_cycle();
            end
            "N": begin
                repeat (a0) begin
                    #8;
                    finish_cycle();
                end
            end
            default: begin
                errors++;
                $display("unknown stimulus command %c", c);
            end
        endcase
    endtask

    initial begin
        rst = 1'b1;
        alloc_en = 1'b0;
        alloc_rd = '0;
        alloc_kind = ooo_pkg::kind_alu;
        alloc_pred_taken = 1'b0;
        wb_en = 1'b0;
        wb_tag = '0;
        wb_data = '0;
        wb_taken = 1'b0;
        wb_target = '0;
        store_done = 1'b0;
        lookup_rs = '0;
        errors = 0;
        cmd_count = 0;
        held_tag = '0;
        commit_expected = 1'b0;
        flush_expected = 1'b0;
        read_stim();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        #8;
        check_value("alloc_ready", 32'd1, 32'(alloc_ready));
        check_value("commit_en", 32'd0, 32'(commit_en));
        check_value("store_en", 32'd0, 32'(store_en));
        check_value("flush", 32'd0, 32'(flush));
        finish_cycle();
        for (int i = 0; i < cmd_count; i++) begin
            run_command(cmd_q[i], arg_q[4*i], arg_q[4*i+1], arg_q[4*i+2], arg_q[4*i+3]);
        end
        $display("commands: %0d, errors: %0d", cmd_count, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    // run length scales with the command count
    initial begin
        wait (cmd_count > 0);
        #(cmd_count * 60 * 20);
        $display("watchdog expired after %0d cycles, errors: %0d", cmd_count * 60, errors);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/ooo_stim.txt ====
# hex fields: A rd kind pred tag | W tag data taken target | D tag | L rs ready value_or_tag
# C rd data | F pc | N cycles | kind 0 alu, 1 branch, 2 store
A 1 0 0 0
A 2 0 0 1
A 3 0 0 2
A 1 0 0 3
A 0 2 0 4
A 5 1 0 5
A 6 0 0 6
A 7 0 0 7
A 8 0 0 0
L 1 0 3
W 2 33 0 0
W 0 11 0 0
C 1 11
L 1 0 3
W 1 22 0 0
C 2 22
C 3 33
L 3 1 33
W 4 0 0 0
W 3 44 0 0
C 1 44
W 5 55 1 200
N 3
D 4
C 5 55
F 200
N 2
L 8 1 0
L 1 1 44
L 5 1 55
A 9 0 0 0
W 0 99 0 0
C 9 99
L 9 1 99
L 0 1 0

// ==== ooo_backend.f ====
logic/ooo_pkg.sv
logic/commit_if.sv
logic/reorder_buffer.sv
logic/rename_table.sv
logic/arch_regfile.sv
logic/ooo_backend.sv
verif/ooo_backend_tb.sv

// ==== Makefile ====
SRCS := $(shell cat ooo_backend.f)

run: obj_dir/Vooo_backend_tb verif/ooo_stim.txt
	./obj_dir/Vooo_backend_tb | tee sim.log
	@if grep -q "Done: errors found" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" sim.log

obj_dir/Vooo_backend_tb: ooo_backend.f $(SRCS)
	verilator --binary --timing --assert --top-module ooo_backend_tb -f ooo_backend.f

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
